/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsuTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$($(OBJDIR)/V$(TOP) $(RUNFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* common/lsuPkg.sv */
package lsuPkg;

	//////////////////////////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////////////////////////
	localparam int DataWidth      = 64; // gpr width
	localparam int BlockBytes     = 16; // bytes per memory block
	localparam int BlockWidth     = 128; // bits per memory block
	localparam int NumBlocks      = 128; // 2 KiB in total
	localparam int BlockAddrWidth = 7; // block index
	localparam int OffsetWidth    = 4; // byte within block
	localparam int RegAddrWidth   = 5; // gpr number
	localparam int ImmWidth       = 16; // D-form displacement
	localparam int OpcodeWidth    = 6; // primary opcode
	localparam int FormatWidth    = 5; // format code from decode
	localparam int FormatD        = 3; // D-form
	localparam int UnitCodeWidth  = 3; // dispatch unit id
	localparam int LsuUnitCode    = 2; // this unit

	//////////////////////////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////////////////////////
	// odd opcodes are the with-update forms
	typedef enum logic [OpcodeWidth-1:0] {
		OpLwz  = 6'd32,
		OpLwzu = 6'd33,
		OpLbz  = 6'd34,
		OpLbzu = 6'd35,
		OpStw  = 6'd36,
		OpStwu = 6'd37,
		OpStb  = 6'd38,
		OpStbu = 6'd39,
		OpLhz  = 6'd40,
		OpLhzu = 6'd41,
		OpLha  = 6'd42,
		OpLhau = 6'd43,
		OpSth  = 6'd44,
		OpSthu = 6'd45
	} lsOpcodeE;

	typedef enum logic [1:0] {
		SizeByte = 2'd0,
		SizeHalf = 2'd1,
		SizeWord = 2'd2
	} accessSizeE;

	typedef logic [BlockWidth-1:0] blockT; // byte 0 sits at the msb end

	typedef struct packed {
		logic                      valid;
		logic                      isLoad;
		logic                      algebraic; // lha/lhau only
		logic                      update; // writes ea back to ra
		accessSizeE                size;
		logic [BlockAddrWidth-1:0] blockAddr;
		logic [OffsetWidth-1:0]    offset; // already aligned down
		logic [DataWidth-1:0]      effAddr;
		logic [RegAddrWidth-1:0]   rtAddr;
		logic [RegAddrWidth-1:0]   raAddr;
		logic [DataWidth-1:0]      storeData; // operand1, low bytes used
		blockT                     block; // memory contents at issue
	} issueT;

	typedef struct packed {
		logic                    enable;
		logic [RegAddrWidth-1:0] address;
		logic [DataWidth-1:0]    value;
	} writebackT;

	typedef struct packed {
		logic                      enable;
		logic [BlockAddrWidth-1:0] blockAddr;
		blockT                     block;
	} memWriteT;

endpackage

/* hdl/lsuTop.sv */
`timescale 1ns/1ps

module lsuTop import lsuPkg::*; (
	input  logic                     clock_i,
	input  logic                     reset_i,
	input  logic                     enable_i,
	input  logic [UnitCodeWidth-1:0] unitCode_i,
	input  logic [FormatWidth-1:0]   format_i,
	input  logic [OpcodeWidth-1:0]   opcode_i,
	input  logic [DataWidth-1:0]     operand1_i, // store data
	input  logic [DataWidth-1:0]     operand2_i, // base
	input  logic [ImmWidth-1:0]      imm_i,
	input  logic [RegAddrWidth-1:0]  rtAddr_i,
	input  logic [RegAddrWidth-1:0]  raAddr_i,
	output logic                     wb1Enable_o,
	output logic [RegAddrWidth-1:0]  wb1Address_o,
	output logic [DataWidth-1:0]     wb1Value_o,
	output logic                     wb2Enable_o,
	output logic [RegAddrWidth-1:0]  wb2Address_o,
	output logic [DataWidth-1:0]     wb2Value_o
);

	logic [BlockAddrWidth-1:0] readAddr; // combinational block index at issue
	blockT                     readBlock;
	issueT                     issueQ; // stage 1
	writebackT                 loadWb; // stage 2, load side
	writebackT                 loadUpdWb;
	memWriteT                  storeMemWrite; // stage 2, store side
	writebackT                 storeUpdWb;
	memWriteT                  memWrite; // into the data store

	lsuIssue issue0 (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.enable_i    (enable_i),
		.unitCode_i  (unitCode_i),
		.format_i    (format_i),
		.opcode_i    (opcode_i),
		.operand1_i  (operand1_i),
		.operand2_i  (operand2_i),
		.imm_i       (imm_i),
		.rtAddr_i    (rtAddr_i),
		.raAddr_i    (raAddr_i),
		.readBlock_i (readBlock),
		.readAddr_o  (readAddr),
		.issue_o     (issueQ)
	);

	dataMemory memory0 (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.readAddr_i  (readAddr),
		.write_i     (memWrite),
		.readBlock_o (readBlock)
	);

	loadAlign load0 (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.issue_i     (issueQ),
		.loadWb_o    (loadWb),
		.loadUpdWb_o (loadUpdWb)
	);

	storeMerge store0 (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.issue_i      (issueQ),
		.memWrite_o   (storeMemWrite),
		.storeUpdWb_o (storeUpdWb)
	);

	writebackStage writeback0 (
		.clock_i         (clock_i),
		.reset_i         (reset_i),
		.loadWb_i        (loadWb),
		.loadUpdWb_i     (loadUpdWb),
		.storeMemWrite_i (storeMemWrite),
		.storeUpdWb_i    (storeUpdWb),
		.memWrite_o      (memWrite),
		.wb1Enable_o     (wb1Enable_o),
		.wb1Address_o    (wb1Address_o),
		.wb1Value_o      (wb1Value_o),
		.wb2Enable_o     (wb2Enable_o),
		.wb2Address_o    (wb2Address_o),
		.wb2Value_o      (wb2Value_o)
	);

endmodule

/* lsu/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory import lsuPkg::*; (
	input  logic                      clock_i,
	input  logic                      reset_i,
	input  logic [BlockAddrWidth-1:0] readAddr_i,
	input  memWriteT                  write_i,
	output blockT                     readBlock_o
);

	blockT mem [NumBlocks]; // 128 x 16 B

	assign readBlock_o = mem[readAddr_i]; // async read, old data on a write edge

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 0; i < NumBlocks; i++) begin
				mem[i] <= '0; // whole store comes up zeroed
			end
		end else if (write_i.enable) begin
			mem[write_i.blockAddr] <= write_i.block; // full block, merge done upstream
		end
	end

endmodule

/* lsu/loadAlign.sv */
`timescale 1ns/1ps

module loadAlign import lsuPkg::*; (
	input  logic      clock_i,
	input  logic      reset_i,
	input  issueT     issue_i,
	output writebackT loadWb_o,
	output writebackT loadUpdWb_o
);

	blockT                shifted; // addressed byte moved to the msb end
	logic [7:0]           byteVal;
	logic [15:0]          halfVal;
	logic [31:0]          wordVal;
	logic [DataWidth-1:0] loadValue;

	assign shifted = issue_i.block << {issue_i.offset, 3'b000};
	assign byteVal = shifted[BlockWidth-1 -: 8];
	assign halfVal = shifted[BlockWidth-1 -: 16];
	assign wordVal = shifted[BlockWidth-1 -: 32];

	always_comb begin
		case (issue_i.size)
			SizeHalf: begin
				if (issue_i.algebraic) begin
					loadValue = {{(DataWidth-16){halfVal[15]}}, halfVal}; // lha
				end else begin
					loadValue = {{(DataWidth-16){1'b0}}, halfVal};
				end
			end
			SizeWord: loadValue = {{(DataWidth-32){1'b0}}, wordVal};
			default:  loadValue = {{(DataWidth-8){1'b0}}, byteVal};
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// stage 2 register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock_i) begin
		loadWb_o.address    <= issue_i.rtAddr;
		loadWb_o.value      <= loadValue;
		loadUpdWb_o.address <= issue_i.raAddr;
		loadUpdWb_o.value   <= issue_i.effAddr; // unaligned ea goes back to ra
		if (reset_i) begin
			loadWb_o.enable    <= 1'b0;
			loadUpdWb_o.enable <= 1'b0;
		end else begin
			loadWb_o.enable    <= issue_i.valid && issue_i.isLoad;
			loadUpdWb_o.enable <= issue_i.valid && issue_i.isLoad && issue_i.update;
		end
	end

endmodule

/* lsu/lsuIssue.sv */
`timescale 1ns/1ps

module lsuIssue import lsuPkg::*; (
	input  logic                      clock_i,
	input  logic                      reset_i,
	input  logic                      enable_i,
	input  logic [UnitCodeWidth-1:0]  unitCode_i,
	input  logic [FormatWidth-1:0]    format_i,
	input  logic [OpcodeWidth-1:0]    opcode_i,
	input  logic [DataWidth-1:0]      operand1_i,
	input  logic [DataWidth-1:0]      operand2_i,
	input  logic [ImmWidth-1:0]       imm_i,
	input  logic [RegAddrWidth-1:0]   rtAddr_i,
	input  logic [RegAddrWidth-1:0]   raAddr_i,
	input  blockT                     readBlock_i,
	output logic [BlockAddrWidth-1:0] readAddr_o,
	output issueT                     issue_o
);

	logic                   known; // opcode is one we implement
	logic                   isLoad;
	logic                   algebraic;
	logic                   update;
	accessSizeE             size;
	logic                   accept;
	logic [DataWidth-1:0]   effAddr;
	logic [OffsetWidth-1:0] offset;
	issueT                  issueNext;

	//////////////////////////////////////////////////////////////////////
	// opcode decode
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		known     = 1'b1;
		isLoad    = 1'b1;
		algebraic = 1'b0;
		update    = opcode_i[0]; // odd opcode means with-update
		size      = SizeByte;
		case (opcode_i)
			OpLbz, OpLbzu: size = SizeByte;
			OpLhz, OpLhzu: size = SizeHalf;
			OpLwz, OpLwzu: size = SizeWord;
			OpLha, OpLhau: begin
				size      = SizeHalf;
				algebraic = 1'b1; // sign extend in stage 2
			end
			OpStb, OpStbu: begin
				size   = SizeByte;
				isLoad = 1'b0;
			end
			OpSth, OpSthu: begin
				size   = SizeHalf;
				isLoad = 1'b0;
			end
			OpStw, OpStwu: begin
				size   = SizeWord;
				isLoad = 1'b0;
			end
			default: known = 1'b0; // lmw/stmw and anything else
		endcase
	end

	assign accept = enable_i && (unitCode_i == UnitCodeWidth'(LsuUnitCode))
		&& (format_i == FormatWidth'(FormatD)) && known;

	//////////////////////////////////////////////////////////////////////
	// effective address
	//////////////////////////////////////////////////////////////////////
	assign effAddr = operand2_i + {{(DataWidth-ImmWidth){imm_i[ImmWidth-1]}}, imm_i}; // ra + d

	always_comb begin
		case (size)
			SizeHalf: offset = {effAddr[OffsetWidth-1:1], 1'b0}; // halfword aligned
			SizeWord: offset = {effAddr[OffsetWidth-1:2], 2'b00}; // word aligned
			default:  offset = effAddr[OffsetWidth-1:0];
		endcase
	end

	assign readAddr_o = effAddr[OffsetWidth +: BlockAddrWidth]; // upper bits wrap

	always_comb begin
		issueNext.valid     = accept;
		issueNext.isLoad    = isLoad;
		issueNext.algebraic = algebraic;
		issueNext.update    = update;
		issueNext.size      = size;
		issueNext.blockAddr = readAddr_o;
		issueNext.offset    = offset;
		issueNext.effAddr   = effAddr;
		issueNext.rtAddr    = rtAddr_i;
		issueNext.raAddr    = raAddr_i;
		issueNext.storeData = operand1_i;
		issueNext.block     = readBlock_i; // same-cycle read
	end

	always_ff @(posedge clock_i) begin
		issue_o <= issueNext;
		if (reset_i) begin
			issue_o.valid <= 1'b0; // stage comes up empty
		end
	end

endmodule

/* lsu/storeMerge.sv */
`timescale 1ns/1ps

module storeMerge import lsuPkg::*; (
	input  logic      clock_i,
	input  logic      reset_i,
	input  issueT     issue_i,
	output memWriteT  memWrite_o,
	output writebackT storeUpdWb_o
);

	logic [BlockBytes-1:0] firstLanes; // lanes for an access at offset 0
	logic [BlockBytes-1:0] byteMask; // lanes actually written
	blockT                 leftData; // store bytes left justified
	blockT                 placed; // store bytes at their offset
	blockT                 merged;

	always_comb begin
		case (issue_i.size)
			SizeHalf: begin
				firstLanes = {2'b11, {(BlockBytes-2){1'b0}}};
				leftData   = {issue_i.storeData[15:0], {(BlockWidth-16){1'b0}}};
			end
			SizeWord: begin
				firstLanes = {4'hf, {(BlockBytes-4){1'b0}}};
				leftData   = {issue_i.storeData[31:0], {(BlockWidth-32){1'b0}}};
			end
			default: begin
				firstLanes = {1'b1, {(BlockBytes-1){1'b0}}};
				leftData   = {issue_i.storeData[7:0], {(BlockWidth-8){1'b0}}};
			end
		endcase
	end

	assign byteMask = firstLanes >> issue_i.offset; // big-endian lane order
	assign placed   = leftData >> {issue_i.offset, 3'b000};

	// mask bit k covers block bits [8k+7:8k]
	always_comb begin
		for (int k = 0; k < BlockBytes; k++) begin
			merged[8*k +: 8] = byteMask[k] ? placed[8*k +: 8] : issue_i.block[8*k +: 8];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stage 2 register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock_i) begin
		memWrite_o.blockAddr  <= issue_i.blockAddr;
		memWrite_o.block      <= merged;
		storeUpdWb_o.address  <= issue_i.raAddr;
		storeUpdWb_o.value    <= issue_i.effAddr;
		if (reset_i) begin
			memWrite_o.enable   <= 1'b0;
			storeUpdWb_o.enable <= 1'b0;
		end else begin
			memWrite_o.enable   <= issue_i.valid && !issue_i.isLoad;
			storeUpdWb_o.enable <= issue_i.valid && !issue_i.isLoad && issue_i.update; // stXu
		end
	end

endmodule

/* lsu/writebackStage.sv */
`timescale 1ns/1ps

module writebackStage import lsuPkg::*; (
	input  logic                    clock_i,
	input  logic                    reset_i,
	input  writebackT               loadWb_i,
	input  writebackT               loadUpdWb_i,
	input  memWriteT                storeMemWrite_i,
	input  writebackT               storeUpdWb_i,
	output memWriteT                memWrite_o,
	output logic                    wb1Enable_o,
	output logic [RegAddrWidth-1:0] wb1Address_o,
	output logic [DataWidth-1:0]    wb1Value_o,
	output logic                    wb2Enable_o,
	output logic [RegAddrWidth-1:0] wb2Address_o,
	output logic [DataWidth-1:0]    wb2Value_o
);

	writebackT port1Q; // rt load result
	writebackT port2Q; // ra update
	writebackT updSel;

	// stage 2 holds one instruction, so at most one update is live
	assign updSel = loadUpdWb_i.enable ? loadUpdWb_i : storeUpdWb_i;

	// block commits at the edge that registers stage 3
	assign memWrite_o = storeMemWrite_i;

	always_ff @(posedge clock_i) begin
		port1Q <= loadWb_i;
		port2Q <= updSel;
		if (reset_i) begin
			port1Q.enable <= 1'b0;
			port2Q.enable <= 1'b0;
		end
	end

	assign wb1Enable_o  = port1Q.enable;
	assign wb1Address_o = port1Q.address;
	assign wb1Value_o   = port1Q.value;
	assign wb2Enable_o  = port2Q.enable;
	assign wb2Address_o = port2Q.address;
	assign wb2Value_o   = port2Q.value;

endmodule

/* testbench/lsuTb.sv */
`timescale 1ns/1ps

module lsuTb import lsuPkg::*; ();

	typedef struct packed {
		logic [31:0] due; // cycle count at which the result is visible
		writebackT   wb1;
		writebackT   wb2;
	} expectT;

	localparam int DrainLimit = 12; // idle cycles allowed to empty the queue

	logic                     clock, reset, enable;
	logic [UnitCodeWidth-1:0] unitCode;
	logic [FormatWidth-1:0]   formatCode;
	logic [OpcodeWidth-1:0]   opcode;
	logic [DataWidth-1:0]     operand1, operand2, base, data;
	logic [ImmWidth-1:0]      imm;
	logic [RegAddrWidth-1:0]  rtAddr, raAddr, wb1Address, wb2Address;
	logic                     wb1Enable, wb2Enable;
	logic [DataWidth-1:0]     wb1Value, wb2Value;

	logic [7:0]  refMem [2048]; // reference byte memory in big-endian blocks
	expectT      expQ [$];
	logic [31:0] cycle = 0;
	integer      seed = 32'h08fb_86b6;
	string       testName;
	int          testChecks, testErrors, totalChecks, totalErrors, tests;
	logic        aborted = 1'b0;
	logic [5:0]  loadOps [3] = '{OpLbz, OpLhz, OpLwz};
	logic [5:0]  storeOps [3] = '{OpStb, OpSth, OpStw};

	lsuTop dut0 (
		.clock_i(clock), .reset_i(reset), .enable_i(enable), .unitCode_i(unitCode),
		.format_i(formatCode), .opcode_i(opcode), .operand1_i(operand1),
		.operand2_i(operand2), .imm_i(imm), .rtAddr_i(rtAddr), .raAddr_i(raAddr),
		.wb1Enable_o(wb1Enable), .wb1Address_o(wb1Address), .wb1Value_o(wb1Value),
		.wb2Enable_o(wb2Enable), .wb2Address_o(wb2Address), .wb2Value_o(wb2Value)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	function automatic logic [63:0] randWord();
		return {$random(seed), $random(seed)};
	endfunction

	// reference behaviour of one accepted instruction
	function automatic expectT applyReference(input logic [5:0] op, input logic [63:0] d,
			input logic [63:0] b, input logic [15:0] ofs, input logic [4:0] rt, input logic [4:0] ra);
		expectT      e;
		logic [63:0] ea;
		logic [63:0] v;
		logic [10:0] a;
		int          nBytes;
		e = '0;
		ea = b + {{48{ofs[15]}}, ofs}; // sign-extended displacement
		case (op)
			OpLbz, OpLbzu, OpStb, OpStbu: nBytes = 1;
			OpLwz, OpLwzu, OpStw, OpStwu: nBytes = 4;
			default:                      nBytes = 2;
		endcase
		a = ea[10:0] & ~11'(nBytes - 1); // aligned down
		if (op inside {OpLwz, OpLwzu, OpLbz, OpLbzu, OpLhz, OpLhzu, OpLha, OpLhau}) begin
			v = '0;
			for (int i = 0; i < nBytes; i++) begin
				v = {v[55:0], refMem[a + 11'(i)]}; // first byte is most significant
			end
			if (op == OpLha || op == OpLhau) begin
				v = {{48{v[15]}}, v[15:0]};
			end
			e.wb1 = {1'b1, rt, v};
		end else begin
			for (int i = 0; i < nBytes; i++) begin
				refMem[a + 11'(i)] = d[8*(nBytes-1-i) +: 8]; // low-order bytes of rs
			end
		end
		if (op inside {OpLwzu, OpLbzu, OpStwu, OpStbu, OpLhzu, OpLhau, OpSthu}) begin
			e.wb2 = {1'b1, ra, ea}; // with-update form
		end
		return e;
	endfunction

	task automatic checkPort(input string port, input writebackT exp, input logic en,
			input logic [4:0] addr, input logic [63:0] value);
		testChecks++;
		assert (en == exp.enable) else begin
			$display("Error %s: %s enable expected %0b actual %0b", testName, port, exp.enable, en);
			testErrors++;
		end
		if (exp.enable && en) begin
			assert (addr == exp.address) else begin
				$display("Error %s: %s address expected %0d actual %0d", testName, port,
					exp.address, addr);
				testErrors++;
			end
			assert (value == exp.value) else begin
				$display("Error %s: %s value expected %h actual %h", testName, port,
					exp.value, value);
				testErrors++;
			end
		end
	endtask

	// compare what is due and drive the next instruction on each falling edge
	task automatic step(input logic en, input logic [2:0] unit, input logic [4:0] fmt,
			input logic [5:0] op, input logic [63:0] d, input logic [63:0] b,
			input logic [15:0] ofs, input logic [4:0] rt, input logic [4:0] ra);
		expectT cur;
		@(negedge clock);
		cycle++;
		cur = '0; // nothing due means both ports idle
		if (expQ.size() > 0 && expQ[0].due == cycle) begin
			cur = expQ.pop_front();
		end
		checkPort("port1", cur.wb1, wb1Enable, wb1Address, wb1Value);
		checkPort("port2", cur.wb2, wb2Enable, wb2Address, wb2Value);
		enable = en;
		unitCode = unit;
		formatCode = fmt;
		opcode = op;
		operand1 = d;
		operand2 = b;
		imm = ofs;
		rtAddr = rt;
		raAddr = ra;
		if (en && unit == 3'(LsuUnitCode) && fmt == 5'(FormatD) && op >= OpLwz && op <= OpSthu) begin
			cur = applyReference(op, d, b, ofs, rt, ra);
			cur.due = cycle + 32'd3; // accepted next edge and visible two edges later
			expQ.push_back(cur);
		end
	endtask

	task automatic exec(input logic [5:0] op, input logic [63:0] d, input logic [63:0] b,
			input logic [15:0] ofs, input logic [4:0] rt, input logic [4:0] ra);
		step(1'b1, 3'(LsuUnitCode), 5'(FormatD), op, d, b, ofs, rt, ra);
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++) begin
			step(1'b0, 3'd0, 5'd0, 6'd0, 64'd0, 64'd0, 16'd0, 5'd0, 5'd0);
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic finishTest();
		for (int i = 0; i < DrainLimit && expQ.size() > 0; i++) begin
			idle(1);
		end
		if (expQ.size() > 0) begin
			$display("%s: %0d expected writebacks never appeared", testName, expQ.size());
			aborted = 1'b1;
		end
		$display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
		totalChecks += testChecks;
		totalErrors += testErrors;
		tests++;
	endtask

	initial begin
		for (int i = 0; i < 2048; i++) begin
			refMem[i] = 8'h00; // memory comes up cleared
		end
		{enable, unitCode, formatCode, opcode, operand1, operand2, imm, rtAddr, raAddr} = '0;
		reset = 1'b1;
		repeat (16) @(posedge clock); // reset seen by 16 rising edges
		@(negedge clock);
		reset = 1'b0;

		startTest("resetLoads"); // back-to-back loads of zeroed memory
		for (int i = 0; i < 6; i++) begin
			exec(loadOps[i % 3], 64'd0, randWord(), 16'h0, 5'(i + 1), 5'd2);
		end
		finishTest();

		if (!aborted) begin
			startTest("roundTrip");
			for (int i = 0; i < 6; i++) begin
				base = randWord();
				exec(storeOps[i % 3], randWord(), base, 16'h0, 5'd0, 5'd3);
				idle(2); // same-block gap
				exec(loadOps[i % 3], 64'd0, base, 16'h0, 5'd7, 5'd3);
			end
			finishTest();
		end

		if (!aborted) begin
			startTest("byteMerge");
			base = randWord();
			base[3:0] = 4'h4; // word at offset 4
			exec(OpStw, randWord(), base, 16'h0, 5'd0, 5'd1);
			idle(2);
			exec(OpStb, randWord(), base, 16'h0, 5'd0, 5'd1);
			idle(2);
			exec(OpStb, randWord(), base, 16'h2, 5'd0, 5'd1); // offset 6
			idle(2);
			exec(OpLwz, 64'd0, base, 16'h0, 5'd12, 5'd1);
			finishTest();
		end

		if (!aborted) begin
			startTest("signExtend");
			base = randWord();
			data = randWord();
			data[15] = 1'b1; // negative halfword
			exec(OpSth, data, base, 16'h0, 5'd0, 5'd4);
			idle(2);
			exec(OpLha, 64'd0, base, 16'h0, 5'd13, 5'd4);
			exec(OpLhz, 64'd0, base, 16'h0, 5'd14, 5'd4);
			finishTest();
		end

		if (!aborted) begin
			startTest("updateForms");
			exec(OpLbzu, 64'd0, randWord(), 16'hffec, 5'd15, 5'd16); // d = -20
			exec(OpLhau, 64'd0, randWord(), 16'h0102, 5'd17, 5'd18);
			exec(OpStwu, randWord(), randWord(), 16'hfff0, 5'd19, 5'd20);
			finishTest();
		end

		if (!aborted) begin
			startTest("ignored");
			base = randWord();
			data = randWord();
			exec(OpStw, data, base, 16'h0, 5'd0, 5'd5);
			idle(2);
			step(1'b1, 3'd5, 5'(FormatD), OpStwu, ~data, base, 16'h0, 5'd1, 5'd2); // wrong unit
			step(1'b1, 3'(LsuUnitCode), 5'd4, OpStwu, ~data, base, 16'h0, 5'd1, 5'd2);
			step(1'b1, 3'(LsuUnitCode), 5'(FormatD), 6'd46, ~data, base, 16'h0, 5'd1, 5'd2);
			step(1'b1, 3'(LsuUnitCode), 5'(FormatD), 6'd47, ~data, base, 16'h0, 5'd1, 5'd2);
			step(1'b0, 3'(LsuUnitCode), 5'(FormatD), OpStwu, ~data, base, 16'h0, 5'd1, 5'd2);
			idle(2);
			exec(OpLwz, 64'd0, base, 16'h0, 5'd9, 5'd5); // still the first word
			exec(OpLwzu, 64'd0, base, 16'h0, 5'd10, 5'd11);
			finishTest();
		end

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, totalChecks,
			totalErrors, dut0.checker0.failCount);
		if (aborted || totalErrors > 0 || dut0.checker0.failCount > 0) begin
			$display("Test failed");
		end else begin
			$display("Test completed successfully");
		end
		$finish;
	end

endmodule

/* testbench/lsuTop_checker.sv */
`timescale 1ns/1ps

module lsuTop_checker import lsuPkg::*; (
	input logic                     clock_i,
	input logic                     reset_i,
	input logic                     enable_i,
	input logic [UnitCodeWidth-1:0] unitCode_i,
	input logic [FormatWidth-1:0]   format_i,
	input logic [OpcodeWidth-1:0]   opcode_i,
	input logic                     wb1Enable_o,
	input logic                     wb2Enable_o
);

	int   failCount = 0; // assertion failures so far
	logic accepted;
	logic acceptLoad;
	logic acceptUpdate;

	assign accepted = !reset_i && enable_i && (unitCode_i == UnitCodeWidth'(LsuUnitCode))
		&& (format_i == FormatWidth'(FormatD)) && (opcode_i >= OpLwz) && (opcode_i <= OpSthu);
	assign acceptLoad = accepted
		&& (opcode_i inside {OpLwz, OpLwzu, OpLbz, OpLbzu, OpLhz, OpLhzu, OpLha, OpLhau});
	assign acceptUpdate = accepted
		&& (opcode_i inside {OpLwzu, OpLbzu, OpStwu, OpStbu, OpLhzu, OpLhau, OpSthu});

	//////////////////////////////////////////////////////////////////////
	// reset and latency
	//////////////////////////////////////////////////////////////////////
	assert property (@(posedge clock_i) (reset_i || $past(reset_i)) |=> (!wb1Enable_o && !wb2Enable_o))
		else begin
			$error("writeback enable high during or right after reset");
			failCount++;
		end

	assert property (@(posedge clock_i) disable iff (reset_i) wb1Enable_o == $past(acceptLoad, 3))
		else begin
			$error("wb1Enable_o does not follow an accepted load by three edges");
			failCount++;
		end

	assert property (@(posedge clock_i) disable iff (reset_i) wb2Enable_o == $past(acceptUpdate, 3))
		else begin
			$error("wb2Enable_o does not follow an accepted update form by three edges");
			failCount++;
		end

endmodule

bind lsuTop lsuTop_checker checker0 (
	.clock_i     (clock_i),
	.reset_i     (reset_i),
	.enable_i    (enable_i),
	.unitCode_i  (unitCode_i),
	.format_i    (format_i),
	.opcode_i    (opcode_i),
	.wb1Enable_o (wb1Enable_o),
	.wb2Enable_o (wb2Enable_o)
);

/* vlog.f */
common/lsuPkg.sv
lsu/lsuIssue.sv
lsu/dataMemory.sv
lsu/loadAlign.sv
lsu/storeMerge.sv
lsu/writebackStage.sv
hdl/lsuTop.sv
testbench/lsuTop_checker.sv
testbench/lsuTb.sv
